// ==== Bender.yml ====
package:
  name: lsu

sources:
  - common/lsu_pkg.sv
  - common/lsu_dec_if.sv
  - lsu/lsu_cmd_decode.sv
  - lsu/lsu_dmem_ctrl.sv
  - lsu/lsu_resp.sv
  - lsu/lsu_top.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/lsu_assert.sv
      - dv/tb_lsu_top.sv

// ==== common/lsu_dec_if.sv ====
/*
 * Decoded command bundle
 * Carries the load/store flags, access width and misalign flag of the
 * command currently presented by the execute stage.
 */

`timescale 1ns/1ns

interface lsu_dec_if;

    logic                  is_load;   // Command is a load
    logic                  is_store;  // Command is a store
    lsu_pkg::mem_width_e   width;     // Access width
    logic                  misalign;  // Misaligned, request present

    // Driven by the command decoder
    modport decode (
        output is_load,
        output is_store,
        output width,
        output misalign
    );

    // Read by the memory controller and the response path
    modport sink (
        input  is_load,
        input  is_store,
        input  width,
        input  misalign
    );

endinterface

// ==== common/lsu_pkg.sv ====
/*
 * Load/store unit shared definitions
 * Data width, command set, memory port encodings and exception causes
 * used by the decoder, the memory controller and the response path.
 */

package lsu_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    localparam int XLEN       = 32;  // Data and address width
    localparam int HWORD_BITS = 16;  // Halfword width
    localparam int BYTE_BITS  = 8;   // Byte width

    // ------------------------------------------------------------------
    // Execute stage command
    // ------------------------------------------------------------------
    typedef enum logic [3:0] {
        CMD_NONE = 4'd0,
        CMD_LB   = 4'd1,  // Load byte, sign extend
        CMD_LBU  = 4'd2,  // Load byte, zero extend
        CMD_LH   = 4'd3,  // Load halfword, sign extend
        CMD_LHU  = 4'd4,  // Load halfword, zero extend
        CMD_LW   = 4'd5,
        CMD_SB   = 4'd6,
        CMD_SH   = 4'd7,
        CMD_SW   = 4'd8
    } lsu_cmd_e;

    // ------------------------------------------------------------------
    // Data memory port
    // ------------------------------------------------------------------
    typedef enum logic [1:0] {
        WIDTH_BYTE  = 2'd0,
        WIDTH_HWORD = 2'd1,
        WIDTH_WORD  = 2'd2
    } mem_width_e;

    typedef enum logic {
        MEM_RD = 1'b0,
        MEM_WR = 1'b1
    } mem_cmd_e;

    // Response is IDLE until the access completes
    typedef enum logic [1:0] {
        RESP_IDLE   = 2'd0,
        RESP_RDY_OK = 2'd1,
        RESP_RDY_ER = 2'd2  // Access fault
    } mem_resp_e;

    // ------------------------------------------------------------------
    // Exception causes, RISC-V mcause numbering
    // ------------------------------------------------------------------
    typedef enum logic [3:0] {
        EXC_NONE             = 4'd0,
        EXC_LD_ADDR_MISALIGN = 4'd4,
        EXC_LD_ACCESS_FAULT  = 4'd5,
        EXC_ST_ADDR_MISALIGN = 4'd6,
        EXC_ST_ACCESS_FAULT  = 4'd7
    } exc_code_e;

endpackage

// ==== dv/lsu_assert.sv ====
/*
 * Load/store unit protocol assertions
 * Bound into the top level, checks the memory handshake and the
 * execute stage outputs
 */

`timescale 1ns/1ns

module lsu_assert (
    input logic               clk,
    input logic               rst_n,
    input logic               req_i,
    input logic               rdy_i,
    input logic               exc_i,
    input logic               dmem_req_i,
    input logic               dmem_req_ack_i,
    input lsu_pkg::mem_resp_e dmem_resp_i,
    input logic               fsm_busy_i      // Controller waits for a response
);

    a_no_req_at_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        rdy_i |-> !dmem_req_i) else $error("dmem_req_o high in a response cycle");

    a_exc_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        exc_i |-> req_i) else $error("exc_o without req_i");

    // Memory answers only while an access is outstanding
    a_no_resp_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !fsm_busy_i |-> dmem_resp_i == lsu_pkg::RESP_IDLE)
        else $error("Memory response while the FSM is idle");

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req_i && !dmem_req_ack_i |=> dmem_req_i)
        else $error("dmem_req_o dropped before acknowledge");

endmodule

bind lsu_top lsu_assert i_lsu_assert (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .rdy_i          (rdy_o),
    .exc_i          (exc_o),
    .dmem_req_i     (dmem_req_o),
    .dmem_req_ack_i (dmem_req_ack_i),
    .dmem_resp_i    (dmem_resp_i),
    .fsm_busy_i     (i_dmem_ctrl.fsm_busy)
);

// ==== dv/tb_clk_gen.sv ====
/*
 * Testbench clock and reset
 * 20 ns clock, active low reset held for two cycles
 */

`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;  // 50 MHz
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);            // Release away from the sampling edge
        rst_n_o = 1'b1;
    end

endmodule

// ==== dv/tb_lsu_top.sv ====
/*
 * Load/store unit testbench
 * Random loads and stores against a behavioral data memory with random
 * acknowledge and response delays, checked against a reference model
 */

`timescale 1ns/1ns

module tb_lsu_top;

    localparam int TIMEOUT = 40;        // Cycles allowed per wait

    typedef struct packed {
        logic [31:0]         ldata;
        logic [31:0]         nword;     // Memory word after a store
        lsu_pkg::mem_width_e width;
        logic                load;
        logic                rdy;
        logic                exc;
        lsu_pkg::exc_code_e  code;
    } exp_t;

    logic                     clk, rst_n;
    logic                     req_i, rdy_o, exc_o;
    lsu_pkg::lsu_cmd_e        cmd_i;
    logic [lsu_pkg::XLEN-1:0] addr_i, sdata_i, ldata_o;
    lsu_pkg::exc_code_e       exc_code_o;
    logic                     dmem_req_o, dmem_req_ack_i;
    lsu_pkg::mem_cmd_e        dmem_cmd_o;
    lsu_pkg::mem_width_e      dmem_width_o;
    logic [lsu_pkg::XLEN-1:0] dmem_addr_o, dmem_wdata_o, dmem_rdata_i;
    lsu_pkg::mem_resp_e       dmem_resp_i;

    logic [31:0] mem [256];             // Memory model contents
    logic [31:0] shadow [256];          // Expected contents
    exp_t        exp_q [$];             // Pending results, in order
    exp_t        cur_exp;               // Command on the execute port
    integer      seed = 32'h772b_7c12;

    tb_clk_gen i_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    lsu_top i_lsu_top (.*);

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    function automatic int rnd(input int range);
        return {$random(seed)} % range;
    endfunction

    function automatic logic [31:0] fill_word(input int i);
        return (i * 32'h9e37_79b1) ^ {i[7:0], ~i[7:0], i[7:0], 8'h3c};
    endfunction

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    function automatic exp_t ref_result(input lsu_pkg::lsu_cmd_e c, input logic [31:0] a,
                                        input logic [31:0] sd, input logic [31:0] w,
                                        input logic flt);
        exp_t r;
        logic mis;
        r.ldata = w;
        r.nword = sd;
        r.width = lsu_pkg::WIDTH_WORD;
        r.load  = c inside {lsu_pkg::CMD_LB, lsu_pkg::CMD_LBU, lsu_pkg::CMD_LH,
                            lsu_pkg::CMD_LHU, lsu_pkg::CMD_LW};
        case (c)
            lsu_pkg::CMD_LB:  r.ldata = {{24{w[7]}}, w[7:0]};
            lsu_pkg::CMD_LBU: r.ldata = {24'h0, w[7:0]};
            lsu_pkg::CMD_LH:  r.ldata = {{16{w[15]}}, w[15:0]};
            lsu_pkg::CMD_LHU: r.ldata = {16'h0, w[15:0]};
            lsu_pkg::CMD_SB:  r.nword = {w[31:8], sd[7:0]};
            lsu_pkg::CMD_SH:  r.nword = {w[31:16], sd[15:0]};
            default: ;
        endcase
        if (c inside {lsu_pkg::CMD_LB, lsu_pkg::CMD_LBU, lsu_pkg::CMD_SB}) begin
            r.width = lsu_pkg::WIDTH_BYTE;
        end else if (c inside {lsu_pkg::CMD_LH, lsu_pkg::CMD_LHU, lsu_pkg::CMD_SH}) begin
            r.width = lsu_pkg::WIDTH_HWORD;
        end
        mis   = (r.width == lsu_pkg::WIDTH_HWORD && a[0]) ||
                (r.width == lsu_pkg::WIDTH_WORD && a[1:0] != 2'b00);
        r.exc = mis | flt;
        r.rdy = !mis;                   // Misaligned never reaches memory
        r.code = lsu_pkg::EXC_NONE;
        if (mis) begin
            r.code = r.load ? lsu_pkg::EXC_LD_ADDR_MISALIGN : lsu_pkg::EXC_ST_ADDR_MISALIGN;
        end else if (flt) begin
            r.code = r.load ? lsu_pkg::EXC_LD_ACCESS_FAULT : lsu_pkg::EXC_ST_ACCESS_FAULT;
        end
        return r;
    endfunction

    // ------------------------------------------------------------------
    // Data memory model, samples on rising and drives on falling edge
    // ------------------------------------------------------------------
    initial begin : mem_model
        logic                busy;
        int                  ack_wait;
        int                  resp_wait;
        logic [31:0]         m_addr;
        logic [31:0]         m_wdata;
        lsu_pkg::mem_cmd_e   m_cmd;
        lsu_pkg::mem_width_e m_width;
        busy           = 1'b0;
        ack_wait       = 0;
        resp_wait      = 0;
        dmem_req_ack_i = 1'b0;
        dmem_resp_i    = lsu_pkg::RESP_IDLE;
        dmem_rdata_i   = '0;
        forever begin
            @(posedge clk);
            if (dmem_resp_i == lsu_pkg::RESP_RDY_OK && m_cmd == lsu_pkg::MEM_WR) begin
                case (m_width)
                    lsu_pkg::WIDTH_BYTE:  mem[m_addr[9:2]][7:0]  = m_wdata[7:0];
                    lsu_pkg::WIDTH_HWORD: mem[m_addr[9:2]][15:0] = m_wdata[15:0];
                    default:              mem[m_addr[9:2]]       = m_wdata;
                endcase
            end
            if (dmem_resp_i != lsu_pkg::RESP_IDLE) begin
                busy = 1'b0;
            end else if (dmem_req_o && dmem_req_ack_i) begin
                busy      = 1'b1;       // Accepted, capture the access
                m_addr    = dmem_addr_o;
                m_wdata   = dmem_wdata_o;
                m_cmd     = dmem_cmd_o;
                m_width   = dmem_width_o;
                resp_wait = 1 + rnd(3);
                ack_wait  = rnd(4);     // Delay for the next request
            end else if (dmem_req_o && ack_wait > 0) begin
                ack_wait--;
            end
            @(negedge clk);
            dmem_req_ack_i = 1'b0;
            dmem_resp_i    = lsu_pkg::RESP_IDLE;
            if (busy) begin
                resp_wait--;
                if (resp_wait == 0) begin
                    dmem_resp_i  = (m_addr >= 32'h800) ? lsu_pkg::RESP_RDY_ER
                                                       : lsu_pkg::RESP_RDY_OK;
                    dmem_rdata_i = mem[m_addr[9:2]];
                end
            end else begin
                dmem_req_ack_i = (ack_wait == 0);
            end
        end
    end

    // ------------------------------------------------------------------
    // Compare process
    // ------------------------------------------------------------------
    always @(posedge clk) begin : compare
        exp_t e;
        if (rst_n && dmem_req_o && dmem_req_ack_i) begin
            check("dmem_cmd_o", dmem_cmd_o, cur_exp.load ? lsu_pkg::MEM_RD : lsu_pkg::MEM_WR);
            check("dmem_width_o", dmem_width_o, cur_exp.width);
            check("dmem_addr_o", dmem_addr_o, addr_i);
            check("dmem_wdata_o", dmem_wdata_o, sdata_i);
        end
        if (rst_n && (rdy_o || exc_o)) begin
            if (exp_q.size() == 0) begin
                $display("Response at %0t with no command pending", $time);
                stop_run();
            end else begin
                e = exp_q.pop_front();
                check("rdy_o", rdy_o, e.rdy);
                check("exc_o", exc_o, e.exc);
                check("exc_code_o", exc_code_o, e.code);
                check("dmem_req_o", dmem_req_o, 1'b0);
                if (e.load && !e.exc) begin
                    check("ldata_o", ldata_o, e.ldata);
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    task automatic run_cmd(input lsu_pkg::lsu_cmd_e c, input logic [31:0] a,
                           input logic [31:0] sd);
        logic done;
        @(negedge clk);
        cur_exp = ref_result(c, a, sd, shadow[a[9:2]], a >= 32'h800);
        cmd_i   = c;
        addr_i  = a;
        sdata_i = sd;
        req_i   = 1'b1;
        exp_q.push_back(cur_exp);
        if (!cur_exp.load && !cur_exp.exc) begin
            shadow[a[9:2]] = cur_exp.nword;
        end
        done = 1'b0;
        for (int n = 0; !done; n++) begin
            if (n == TIMEOUT) begin
                $display("Timeout waiting for rdy_o or exc_o on %s", c.name());
                stop_run();
            end else begin
                @(posedge clk);
                done = rdy_o | exc_o;
            end
        end
    endtask

    initial begin : stimulus
        lsu_pkg::lsu_cmd_e c;
        logic [31:0]       a;
        logic [1:0]        lsb;
        req_i   = 1'b0;
        cmd_i   = lsu_pkg::CMD_NONE;
        addr_i  = '0;
        sdata_i = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i]    = fill_word(i);
            shadow[i] = fill_word(i);
        end
        // Outputs quiet in reset and the first cycle after
        for (int n = 0; rst_n !== 1'b1; n++) begin
            if (n == TIMEOUT) begin
                $display("Reset was never released");
                stop_run();
            end else begin
                @(posedge clk);
                check("rdy_o in reset", rdy_o, 1'b0);
                check("exc_o in reset", exc_o, 1'b0);
                check("dmem_req_o in reset", dmem_req_o, 1'b0);
            end
        end
        for (int k = 0; k < 300; k++) begin
            c   = lsu_pkg::lsu_cmd_e'(1 + rnd(8));
            lsb = (rnd(3) == 0) ? 2'(rnd(4)) : 2'b00;  // Some misaligned
            a   = ((rnd(8) == 0) ? 32'h800 : 32'h0) | (32'(rnd(256)) << 2) | 32'(lsb);
            run_cmd(c, a, $random(seed));
            if (c inside {lsu_pkg::CMD_SB, lsu_pkg::CMD_SH, lsu_pkg::CMD_SW}) begin
                run_cmd(lsu_pkg::CMD_LW, a & 32'hffff_fffc, 32'h0);  // Read back
            end
            if (rnd(4) == 0) begin
                @(negedge clk);
                req_i = 1'b0;           // Idle gap
            end
        end
        @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d commands never completed", exp_q.size());
            stop_run();
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// ==== lsu/lsu_cmd_decode.sv ====
/*
 * Command decoder
 * Classifies the execute stage command as load or store, selects the
 * memory access width and flags misaligned halfword and word accesses.
 * Purely combinational.
 */

`timescale 1ns/1ns

module lsu_cmd_decode (
    input  logic              req_i,       // Command valid
    input  lsu_pkg::lsu_cmd_e cmd_i,       // Command
    input  logic [1:0]        addr_lsb_i,  // Address bits [1:0]
    lsu_dec_if.decode         dec          // Decoded command
);

    logic wdth_byte;   // Byte access
    logic wdth_hword;  // Halfword access
    logic wdth_word;   // Word access

    // ------------------------------------------------------------------
    // Command class
    // ------------------------------------------------------------------
    assign dec.is_load  = cmd_i inside {lsu_pkg::CMD_LB, lsu_pkg::CMD_LBU,
                                        lsu_pkg::CMD_LH, lsu_pkg::CMD_LHU,
                                        lsu_pkg::CMD_LW};
    assign dec.is_store = cmd_i inside {lsu_pkg::CMD_SB, lsu_pkg::CMD_SH,
                                        lsu_pkg::CMD_SW};

    // ------------------------------------------------------------------
    // Access width
    // ------------------------------------------------------------------
    assign wdth_byte  = cmd_i inside {lsu_pkg::CMD_LB, lsu_pkg::CMD_LBU, lsu_pkg::CMD_SB};
    assign wdth_hword = cmd_i inside {lsu_pkg::CMD_LH, lsu_pkg::CMD_LHU, lsu_pkg::CMD_SH};
    assign wdth_word  = cmd_i inside {lsu_pkg::CMD_LW, lsu_pkg::CMD_SW};

    // NONE falls through to word, no access follows anyway
    assign dec.width = wdth_byte  ? lsu_pkg::WIDTH_BYTE  :
                       wdth_hword ? lsu_pkg::WIDTH_HWORD :
                                    lsu_pkg::WIDTH_WORD;

    // ------------------------------------------------------------------
    // Misalign detection
    // ------------------------------------------------------------------
    // Halfword needs bit 0 clear, word needs both bits clear
    assign dec.misalign = req_i & ((wdth_hword & addr_lsb_i[0]) |
                                   (wdth_word  & (|addr_lsb_i)));

endmodule

// ==== lsu/lsu_dmem_ctrl.sv ====
/*
 * Data memory controller
 * Two-state FSM for the request/acknowledge and response protocol.
 * Latches the command on acceptance, drives the memory request and
 * turns the memory response into ok/error strobes.
 */

`timescale 1ns/1ns

module lsu_dmem_ctrl (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         req_i,           // Execute stage request
    input  lsu_pkg::lsu_cmd_e            cmd_i,
    input  logic [lsu_pkg::XLEN-1:0]     addr_i,
    input  logic [lsu_pkg::XLEN-1:0]     sdata_i,
    lsu_dec_if.sink                      dec,             // Decoded command
    input  logic                         dmem_req_ack_i,
    input  lsu_pkg::mem_resp_e           dmem_resp_i,
    output logic                         dmem_req_o,
    output lsu_pkg::mem_cmd_e            dmem_cmd_o,
    output lsu_pkg::mem_width_e          dmem_width_o,
    output logic [lsu_pkg::XLEN-1:0]     dmem_addr_o,
    output logic [lsu_pkg::XLEN-1:0]     dmem_wdata_o,
    output lsu_pkg::lsu_cmd_e            cmd_ff_o,        // Command in flight
    output logic                         resp_ok_o,
    output logic                         resp_er_o
);

    logic fsm_busy;   // 0 idle, 1 waiting for response
    logic req_accept; // Request taken by memory
    logic resp_done;  // Response received

    // ------------------------------------------------------------------
    // Response decode
    // ------------------------------------------------------------------
    assign resp_ok_o = (dmem_resp_i == lsu_pkg::RESP_RDY_OK);
    assign resp_er_o = (dmem_resp_i == lsu_pkg::RESP_RDY_ER);
    assign resp_done = resp_ok_o | resp_er_o;

    // ------------------------------------------------------------------
    // FSM and command register
    // ------------------------------------------------------------------
    assign req_accept = dmem_req_o & dmem_req_ack_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fsm_busy <= 1'b0;
            cmd_ff_o <= lsu_pkg::CMD_NONE;
        end else if (!fsm_busy) begin
            if (req_accept) begin
                fsm_busy <= 1'b1;
                cmd_ff_o <= cmd_i;  // Selects extension at response
            end
        end else if (resp_done) begin
            fsm_busy <= 1'b0;       // Back to idle in the next cycle
        end
    end

    // ------------------------------------------------------------------
    // Memory request
    // ------------------------------------------------------------------
    // Misaligned commands never reach memory
    assign dmem_req_o   = req_i & ~fsm_busy & ~dec.misalign;
    assign dmem_cmd_o   = dec.is_store ? lsu_pkg::MEM_WR : lsu_pkg::MEM_RD;
    assign dmem_width_o = dec.width;
    assign dmem_addr_o  = addr_i;   // Held stable by execute stage
    assign dmem_wdata_o = sdata_i;

endmodule

// ==== lsu/lsu_resp.sv ====
/*
 * Response path
 * Sign- or zero-extends memory read data by the latched command, and
 * builds the ready, exception flag and exception code towards the
 * execute stage. Combinational.
 */

`timescale 1ns/1ns

module lsu_resp (
    input  lsu_pkg::lsu_cmd_e            cmd_ff_i,   // Latched command
    input  logic                         resp_ok_i,
    input  logic                         resp_er_i,  // Access fault
    input  logic [lsu_pkg::XLEN-1:0]     rdata_i,    // Memory read data
    lsu_dec_if.sink                      dec,        // Current command
    output logic                         rdy_o,
    output logic [lsu_pkg::XLEN-1:0]     ldata_o,
    output logic                         exc_o,
    output lsu_pkg::exc_code_e           exc_code_o
);

    localparam int HB = lsu_pkg::HWORD_BITS;
    localparam int BB = lsu_pkg::BYTE_BITS;

    logic ff_load;   // Latched command is a load
    logic ff_store;  // Latched command is a store

    assign ff_load  = cmd_ff_i inside {lsu_pkg::CMD_LB, lsu_pkg::CMD_LBU,
                                       lsu_pkg::CMD_LH, lsu_pkg::CMD_LHU,
                                       lsu_pkg::CMD_LW};
    assign ff_store = cmd_ff_i inside {lsu_pkg::CMD_SB, lsu_pkg::CMD_SH,
                                       lsu_pkg::CMD_SW};

    // ------------------------------------------------------------------
    // Load data extension
    // ------------------------------------------------------------------
    always_comb begin
        case (cmd_ff_i)
            lsu_pkg::CMD_LH:  ldata_o = {{(lsu_pkg::XLEN-HB){rdata_i[HB-1]}}, rdata_i[HB-1:0]};
            lsu_pkg::CMD_LHU: ldata_o = {{(lsu_pkg::XLEN-HB){1'b0}}, rdata_i[HB-1:0]};
            lsu_pkg::CMD_LB:  ldata_o = {{(lsu_pkg::XLEN-BB){rdata_i[BB-1]}}, rdata_i[BB-1:0]};
            lsu_pkg::CMD_LBU: ldata_o = {{(lsu_pkg::XLEN-BB){1'b0}}, rdata_i[BB-1:0]};
            default:          ldata_o = rdata_i;  // Word
        endcase
    end

    // ------------------------------------------------------------------
    // Ready and exceptions
    // ------------------------------------------------------------------
    assign rdy_o = resp_ok_i | resp_er_i;   // Response cycle only
    assign exc_o = resp_er_i | dec.misalign;

    // Access fault first, then misalign; zero when no exception
    always_comb begin
        exc_code_o = lsu_pkg::EXC_NONE;
        if (resp_er_i) begin
            if (ff_load) begin
                exc_code_o = lsu_pkg::EXC_LD_ACCESS_FAULT;
            end else if (ff_store) begin
                exc_code_o = lsu_pkg::EXC_ST_ACCESS_FAULT;
            end
        end else if (dec.misalign) begin
            if (dec.is_load) begin
                exc_code_o = lsu_pkg::EXC_LD_ADDR_MISALIGN;
            end else if (dec.is_store) begin
                exc_code_o = lsu_pkg::EXC_ST_ADDR_MISALIGN;
            end
        end
    end

endmodule

// ==== lsu/lsu_top.sv ====
/*
 * Load/store unit top level
 * Accepts one load or store at a time from the execute stage and runs
 * it on the data memory port. Returns extended load data, address
 * misalign and access fault exceptions.
 */

`timescale 1ns/1ns

module lsu_top (
    input  logic                         clk,
    input  logic                         rst_n,

    // ------------------------------------------------------------------
    // Execute stage side
    // ------------------------------------------------------------------
    input  logic                         req_i,           // Held until rdy_o or exc_o
    input  lsu_pkg::lsu_cmd_e            cmd_i,
    input  logic [lsu_pkg::XLEN-1:0]     addr_i,
    input  logic [lsu_pkg::XLEN-1:0]     sdata_i,         // Store data
    output logic                         rdy_o,           // Memory response cycle
    output logic [lsu_pkg::XLEN-1:0]     ldata_o,         // Extended load data
    output logic                         exc_o,
    output lsu_pkg::exc_code_e           exc_code_o,

    // ------------------------------------------------------------------
    // Data memory side
    // ------------------------------------------------------------------
    output logic                         dmem_req_o,
    output lsu_pkg::mem_cmd_e            dmem_cmd_o,
    output lsu_pkg::mem_width_e          dmem_width_o,
    output logic [lsu_pkg::XLEN-1:0]     dmem_addr_o,
    output logic [lsu_pkg::XLEN-1:0]     dmem_wdata_o,
    input  logic                         dmem_req_ack_i,
    input  logic [lsu_pkg::XLEN-1:0]     dmem_rdata_i,
    input  lsu_pkg::mem_resp_e           dmem_resp_i
);

    lsu_pkg::lsu_cmd_e cmd_ff;   // Command in flight
    logic              resp_ok;
    logic              resp_er;

    lsu_dec_if i_dec_if ();      // Decoded current command

    lsu_cmd_decode i_cmd_decode (
        .req_i      (req_i),
        .cmd_i      (cmd_i),
        .addr_lsb_i (addr_i[1:0]),
        .dec        (i_dec_if.decode)
    );

    lsu_dmem_ctrl i_dmem_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_i          (req_i),
        .cmd_i          (cmd_i),
        .addr_i         (addr_i),
        .sdata_i        (sdata_i),
        .dec            (i_dec_if.sink),
        .dmem_req_ack_i (dmem_req_ack_i),
        .dmem_resp_i    (dmem_resp_i),
        .dmem_req_o     (dmem_req_o),
        .dmem_cmd_o     (dmem_cmd_o),
        .dmem_width_o   (dmem_width_o),
        .dmem_addr_o    (dmem_addr_o),
        .dmem_wdata_o   (dmem_wdata_o),
        .cmd_ff_o       (cmd_ff),
        .resp_ok_o      (resp_ok),
        .resp_er_o      (resp_er)
    );

    lsu_resp i_resp (
        .cmd_ff_i   (cmd_ff),
        .resp_ok_i  (resp_ok),
        .resp_er_i  (resp_er),
        .rdata_i    (dmem_rdata_i),
        .dec        (i_dec_if.sink),
        .rdy_o      (rdy_o),
        .ldata_o    (ldata_o),
        .exc_o      (exc_o),
        .exc_code_o (exc_code_o)
    );

endmodule

// ==== project.f ====
common/lsu_pkg.sv
common/lsu_dec_if.sv
lsu/lsu_cmd_decode.sv
lsu/lsu_dmem_ctrl.sv
lsu/lsu_resp.sv
lsu/lsu_top.sv
dv/tb_clk_gen.sv
dv/lsu_assert.sv
dv/tb_lsu_top.sv
